/* gw_pkg.sv */
package gw_pkg;

  //////////////////////////////////////////////////
  // Link and memory sizing

  // Outside request links merged by the concentrator
  localparam int num_ports_lp = 4;

  // Word addressed, one word per address
  localparam int addr_width_lp = 10;
  localparam int data_width_lp = 32;

  localparam int mem_words_lp = 2 ** addr_width_lp;

  // Index width for the rotating turn registers
  localparam int port_id_width_lp = $clog2(num_ports_lp);

  //////////////////////////////////////////////////
  // Memory link payloads

  // Request toward the test memory
  typedef struct packed {
    logic                     write;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;
  } mem_req_s;

  // Response back to the issuing port
  // Write responses carry the written word back
  typedef struct packed {
    logic                     write;
    logic [data_width_lp-1:0] data;
  } mem_resp_s;

  //////////////////////////////////////////////////
  // Tag control payload

  // Shifted in MSB first, so padding arrives before reset
  typedef struct packed {
    logic padding;
    logic reset;
  } tag_payload_s;

  localparam int tag_len_lp = $bits(tag_payload_s);

endpackage

/* gw_fifo.sv */
module gw_fifo #(
  parameter type payload_t = logic,
  parameter int  depth_p   = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  localparam int ptr_width_lp   = $clog2(depth_p);
  localparam int count_width_lp = $clog2(depth_p + 1);

  localparam logic [ptr_width_lp-1:0]   last_ptr_lp = ptr_width_lp'(depth_p - 1);
  localparam logic [count_width_lp-1:0] full_lp     = count_width_lp'(depth_p);

  // Circular storage addressed by the two pointers
  payload_t mem_r [depth_p];

  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [count_width_lp-1:0] count_r;
  logic [count_width_lp-1:0] count_n;
  logic                      ready_r;
  logic                      v_r;
  logic                      enq;
  logic                      deq;

  assign enq = v_i & ready_r;
  assign deq = yumi_i & v_r;

  always_comb begin
    count_n = count_r;
    if (enq && !deq) begin
      count_n = count_r + 1'b1;
    end else if (deq && !enq) begin
      count_n = count_r - 1'b1;
    end
  end

  // Flags registered from the next count, low during reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
      ready_r  <= 1'b0;
      v_r      <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == last_ptr_lp) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == last_ptr_lp) ? '0 : rd_ptr_r + 1'b1;
      end
      count_r <= count_n;
      ready_r <= (count_n != full_lp);
      v_r     <= (count_n != '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign ready_o = ready_r;
  assign v_o     = v_r;
  assign data_o  = mem_r[rd_ptr_r];

  // Consumer only pops what is shown
  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o);

  // Full and not draining, so the write side must not move
  a_no_write_full: assert property (@(posedge clk_i) disable iff (reset_i)
    (count_r == full_lp && !deq) |=> $stable(wr_ptr_r));

endmodule

/* gw_tag_client.sv */
module gw_tag_client (
  input  logic                 hb_clk_i,
  input  logic                 rst_n_i,

  input  logic                 tag_en_i,
  input  logic                 tag_data_i,

  output gw_pkg::tag_payload_s tag_data_o,
  output logic                 tag_new_o
);

  // Bits held before the final one arrives
  localparam int shift_width_lp = gw_pkg::tag_len_lp - 1;
  localparam int cnt_width_lp   = $clog2(gw_pkg::tag_len_lp + 1);

  localparam logic [cnt_width_lp-1:0] last_cnt_lp = cnt_width_lp'(gw_pkg::tag_len_lp - 1);

  logic [shift_width_lp-1:0]     shift_r;
  logic [gw_pkg::tag_len_lp-1:0] shift_n;
  logic [cnt_width_lp-1:0]       cnt_r;
  logic                          last_bit;

  gw_pkg::tag_payload_s tag_r;
  logic                 new_r;

  //////////////////////////////////////////////////
  // Serial assembly

  // MSB first, new bit enters at the bottom
  assign shift_n  = {shift_r, tag_data_i};
  assign last_bit = tag_en_i & (cnt_r == last_cnt_lp);

  always_ff @(posedge hb_clk_i) begin
    if (tag_en_i) begin
      shift_r <= shift_n[shift_width_lp-1:0];
    end
  end

  always_ff @(posedge hb_clk_i) begin
    if (!rst_n_i) begin
      cnt_r <= '0;
    end else if (last_bit) begin
      cnt_r <= '0;
    end else if (tag_en_i) begin
      cnt_r <= cnt_r + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Payload register

  // Comes out of reset holding the complex in reset
  always_ff @(posedge hb_clk_i) begin
    if (!rst_n_i) begin
      tag_r         <= '0;
      tag_r.reset   <= 1'b1;
      new_r         <= 1'b0;
    end else begin
      new_r <= last_bit;
      if (last_bit) begin
        tag_r <= gw_pkg::tag_payload_s'(shift_n);
      end
    end
  end

  assign tag_data_o = tag_r;
  assign tag_new_o  = new_r;

endmodule

/* gw_link_rr_static.sv */
module gw_link_rr_static (
  input  logic                                          clk_i,
  input  logic                                          reset_i,

  // Outside links
  input  logic              [gw_pkg::num_ports_lp-1:0] links_v_i,
  input  gw_pkg::mem_req_s  [gw_pkg::num_ports_lp-1:0] links_data_i,
  output logic              [gw_pkg::num_ports_lp-1:0] links_ready_o,

  output logic              [gw_pkg::num_ports_lp-1:0] links_resp_v_o,
  output gw_pkg::mem_resp_s [gw_pkg::num_ports_lp-1:0] links_resp_o,
  input  logic              [gw_pkg::num_ports_lp-1:0] links_resp_ready_i,

  // Memory side
  output logic                                          single_v_o,
  output gw_pkg::mem_req_s                              single_data_o,
  input  logic                                          single_ready_i,

  input  logic                                          single_resp_v_i,
  input  gw_pkg::mem_resp_s                             single_resp_i,
  output logic                                          single_resp_ready_o
);

  localparam logic [gw_pkg::port_id_width_lp-1:0] last_port_lp =
    gw_pkg::port_id_width_lp'(gw_pkg::num_ports_lp - 1);

  logic [gw_pkg::port_id_width_lp-1:0] req_turn_r;
  logic [gw_pkg::port_id_width_lp-1:0] resp_turn_r;
  logic                                req_xfer;
  logic                                resp_xfer;

  //////////////////////////////////////////////////
  // Request path

  // Only the port holding the turn is forwarded
  assign single_v_o    = links_v_i[req_turn_r];
  assign single_data_o = links_data_i[req_turn_r];

  always_comb begin
    links_ready_o             = '0;
    links_ready_o[req_turn_r] = single_ready_i;
  end

  assign req_xfer = single_v_o & single_ready_i;

  //////////////////////////////////////////////////
  // Response path

  // Memory answers in order, so the response turn
  // always points at the oldest outstanding request
  always_comb begin
    links_resp_v_o              = '0;
    links_resp_v_o[resp_turn_r] = single_resp_v_i;
    for (int i = 0; i < gw_pkg::num_ports_lp; i++) begin
      links_resp_o[i] = single_resp_i;
    end
  end

  assign single_resp_ready_o = links_resp_ready_i[resp_turn_r];
  assign resp_xfer           = single_resp_v_i & single_resp_ready_o;

  // Turns rotate one step per transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_turn_r  <= '0;
      resp_turn_r <= '0;
    end else begin
      if (req_xfer) begin
        req_turn_r <= (req_turn_r == last_port_lp) ? '0 : req_turn_r + 1'b1;
      end
      if (resp_xfer) begin
        resp_turn_r <= (resp_turn_r == last_port_lp) ? '0 : resp_turn_r + 1'b1;
      end
    end
  end

  a_one_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(links_ready_o));

  // A stalled request on the turn port must be held by its sender
  a_req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (single_v_o && !single_ready_i) |=> (single_v_o && $stable(single_data_o)));

endmodule

/* gw_test_mem.sv */
module gw_test_mem (
  input  logic              clk_i,
  input  logic              reset_i,

  input  logic              req_v_i,
  input  gw_pkg::mem_req_s  req_i,
  output logic              req_ready_o,

  output logic              resp_v_o,
  output gw_pkg::mem_resp_s resp_o,
  input  logic              resp_ready_i
);

  logic [gw_pkg::data_width_lp-1:0] mem_r [gw_pkg::mem_words_lp];

  logic              req_fifo_v;
  gw_pkg::mem_req_s  req_fifo_data;
  logic              req_yumi;

  gw_pkg::mem_resp_s resp_li;
  logic              resp_fifo_ready;
  logic              resp_yumi;

  //////////////////////////////////////////////////
  // Request queue

  gw_fifo #(
    .payload_t (gw_pkg::mem_req_s),
    .depth_p   (4)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_v_i),
    .data_i  (req_i),
    .ready_o (req_ready_o),
    .v_o     (req_fifo_v),
    .data_o  (req_fifo_data),
    .yumi_i  (req_yumi)
  );

  //////////////////////////////////////////////////
  // Array access

  // Pop only when the response has somewhere to go
  assign req_yumi = req_fifo_v & resp_fifo_ready;

  always_ff @(posedge clk_i) begin
    if (req_yumi && req_fifo_data.write) begin
      mem_r[req_fifo_data.addr] <= req_fifo_data.data;
    end
  end

  // Write echoes its own data, read returns the stored word
  always_comb begin
    resp_li.write = req_fifo_data.write;
    if (req_fifo_data.write) begin
      resp_li.data = req_fifo_data.data;
    end else begin
      resp_li.data = mem_r[req_fifo_data.addr];
    end
  end

  //////////////////////////////////////////////////
  // Response queue

  assign resp_yumi = resp_v_o & resp_ready_i;

  gw_fifo #(
    .payload_t (gw_pkg::mem_resp_s),
    .depth_p   (4)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (req_yumi),
    .data_i  (resp_li),
    .ready_o (resp_fifo_ready),
    .v_o     (resp_v_o),
    .data_o  (resp_o),
    .yumi_i  (resp_yumi)
  );

endmodule

/* gw_core_complex.sv */
module gw_core_complex (
  input  logic                                          hb_clk_i,
  input  logic                                          rst_n_i,

  input  logic                                          tag_en_i,
  input  logic                                          tag_data_i,
  input  logic                                          tag_trace_done_i,

  input  logic              [gw_pkg::num_ports_lp-1:0] req_v_i,
  input  gw_pkg::mem_req_s  [gw_pkg::num_ports_lp-1:0] req_i,
  output logic              [gw_pkg::num_ports_lp-1:0] req_ready_o,

  output logic              [gw_pkg::num_ports_lp-1:0] resp_v_o,
  output gw_pkg::mem_resp_s [gw_pkg::num_ports_lp-1:0] resp_o,
  input  logic              [gw_pkg::num_ports_lp-1:0] resp_ready_i
);

  gw_pkg::tag_payload_s tag_data_lo;
  logic                 tag_new_lo;
  logic                 core_reset;

  logic                 mem_v_li;
  gw_pkg::mem_req_s     mem_req_li;
  logic                 mem_ready_lo;
  logic                 mem_resp_v_lo;
  gw_pkg::mem_resp_s    mem_resp_lo;
  logic                 mem_resp_ready_li;

  //////////////////////////////////////////////////
  // Tag client and core reset

  gw_tag_client u_tag_client (
    .hb_clk_i   (hb_clk_i),
    .rst_n_i    (rst_n_i),
    .tag_en_i   (tag_en_i),
    .tag_data_i (tag_data_i),
    .tag_data_o (tag_data_lo),
    .tag_new_o  (tag_new_lo)
  );

  // Any one source holds the concentrator and memory in reset
  assign core_reset = ~rst_n_i | tag_data_lo.reset | ~tag_trace_done_i;

  //////////////////////////////////////////////////
  // Concentrator and test memory

  gw_link_rr_static u_link_rr (
    .clk_i               (hb_clk_i),
    .reset_i             (core_reset),
    .links_v_i           (req_v_i),
    .links_data_i        (req_i),
    .links_ready_o       (req_ready_o),
    .links_resp_v_o      (resp_v_o),
    .links_resp_o        (resp_o),
    .links_resp_ready_i  (resp_ready_i),
    .single_v_o          (mem_v_li),
    .single_data_o       (mem_req_li),
    .single_ready_i      (mem_ready_lo),
    .single_resp_v_i     (mem_resp_v_lo),
    .single_resp_i       (mem_resp_lo),
    .single_resp_ready_o (mem_resp_ready_li)
  );

  gw_test_mem u_test_mem (
    .clk_i        (hb_clk_i),
    .reset_i      (core_reset),
    .req_v_i      (mem_v_li),
    .req_i        (mem_req_li),
    .req_ready_o  (mem_ready_lo),
    .resp_v_o     (mem_resp_v_lo),
    .resp_o       (mem_resp_lo),
    .resp_ready_i (mem_resp_ready_li)
  );

  // New tag asking for reset quiets every port on the next cycle
  a_tag_reset_quiets: assert property (@(posedge hb_clk_i) disable iff (!rst_n_i)
    (tag_new_lo && tag_data_lo.reset) |=> (req_ready_o == '0 && resp_v_o == '0));

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Low for the first two rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* tb_gw_core_complex.sv */
module tb_gw_core_complex;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeout_lp     = 200;
  localparam int stall_wait_lp  = 40;
  localparam int hold_cycles_lp = 20;
  localparam int num_entries_lp = 16;

  typedef struct packed {
    logic [gw_pkg::port_id_width_lp-1:0] port;
    gw_pkg::mem_req_s                    req;
    logic [gw_pkg::data_width_lp-1:0]    exp;
  } entry_s;

  typedef struct packed {
    logic [gw_pkg::port_id_width_lp-1:0] port;
    gw_pkg::mem_resp_s                   resp;
  } exp_resp_s;

  logic hb_clk;
  logic rst_n;
  logic tag_en;
  logic tag_data;
  logic trace_done;

  logic              [gw_pkg::num_ports_lp-1:0] req_v;
  gw_pkg::mem_req_s  [gw_pkg::num_ports_lp-1:0] req;
  logic              [gw_pkg::num_ports_lp-1:0] req_ready;
  logic              [gw_pkg::num_ports_lp-1:0] resp_v;
  gw_pkg::mem_resp_s [gw_pkg::num_ports_lp-1:0] resp;
  logic              [gw_pkg::num_ports_lp-1:0] resp_ready;

  entry_s      stim_tbl [num_entries_lp];
  exp_resp_s   exp_q [$];
  logic [31:0] model [gw_pkg::mem_words_lp];
  logic [31:0] lcg_state = 32'h3d71c1d3;
  int          errors = 0;
  int          turn = 0;

  tb_clk_gen u_clk_gen (
    .clk_o   (hb_clk),
    .rst_n_o (rst_n)
  );

  gw_core_complex u_gw_core_complex (
    .hb_clk_i         (hb_clk),
    .rst_n_i          (rst_n),
    .tag_en_i         (tag_en),
    .tag_data_i       (tag_data),
    .tag_trace_done_i (trace_done),
    .req_v_i          (req_v),
    .req_i            (req),
    .req_ready_o      (req_ready),
    .resp_v_o         (resp_v),
    .resp_o           (resp),
    .resp_ready_i     (resp_ready)
  );

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic gw_pkg::mem_req_s make_req(input logic w, input int a, input logic [31:0] d);
    gw_pkg::mem_req_s r;
    r.write = w;
    r.addr  = gw_pkg::addr_width_lp'(a);
    r.data  = d;
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("error %s expected %0h actual %0h", name, exp, act);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  // Writes first, then reads from the next writer's address
  function automatic void build_table();
    int a;
    for (int i = 0; i < num_entries_lp; i++) begin
      a = ((i < 8) ? i : (i + 1) % 8) * 37 + 5;
      stim_tbl[i].port = gw_pkg::port_id_width_lp'(i % 4);
      if (i < 8) begin
        stim_tbl[i].req = make_req(1'b1, a, lcg_next());
        model[a]        = stim_tbl[i].req.data;
      end else begin
        stim_tbl[i].req = make_req(1'b0, a, '0);
      end
      stim_tbl[i].exp = model[a];
    end
  endfunction

  task automatic post_req(input int p, input gw_pkg::mem_req_s r);
    @(posedge hb_clk);
    req_v[p] <= 1'b1;
    req[p]   <= r;
  endtask

  task automatic wait_accept(input int p, input logic wr, input logic [31:0] exp_data,
                             input int limit, output bit ok);
    exp_resp_s e;
    ok = 1'b0;
    for (int i = 0; i < limit; i++) begin
      @(posedge hb_clk);
      if (req_ready[p]) begin
        ok = 1'b1;
        break;
      end
    end
    if (ok) begin
      req_v[p]    <= 1'b0;
      e.port      = gw_pkg::port_id_width_lp'(p);
      e.resp.write = wr;
      e.resp.data  = exp_data;
      exp_q.push_back(e);
      turn = (turn + 1) % gw_pkg::num_ports_lp;
    end
  endtask

  task automatic send(input int p, input gw_pkg::mem_req_s r, input logic [31:0] exp_data);
    bit ok;
    post_req(p, r);
    wait_accept(p, r.write, exp_data, timeout_lp, ok);
    if (!ok) note_failure($sformatf("port %0d request not accepted within timeout", p));
  endtask

  task automatic send_tag(input logic pad, input logic rst_bit);
    gw_pkg::tag_payload_s            t;
    logic [gw_pkg::tag_len_lp-1:0] bits;
    t.padding = pad;
    t.reset   = rst_bit;
    bits      = t;
    // MSB first, with a shrinking gap between strobes
    for (int i = gw_pkg::tag_len_lp - 1; i >= 0; i--) begin
      @(posedge hb_clk);
      tag_en   <= 1'b1;
      tag_data <= bits[i];
      @(posedge hb_clk);
      tag_en   <= 1'b0;
      repeat (i + 2) @(posedge hb_clk);
    end
  endtask

  task automatic wait_ready(input string what);
    bit ok;
    ok = 1'b0;
    for (int i = 0; i < timeout_lp; i++) begin
      @(posedge hb_clk);
      if (req_ready != '0) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) note_failure({"no port became ready after ", what});
  endtask

  task automatic wait_quiet(input string what);
    bit ok;
    ok = 1'b0;
    for (int i = 0; i < timeout_lp; i++) begin
      @(posedge hb_clk);
      if (req_ready == '0 && resp_v == '0) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) note_failure({"ports still active after ", what});
  endtask

  // Queue is read away from the rising edge
  task automatic drain();
    for (int i = 0; i < timeout_lp; i++) begin
      @(negedge hb_clk);
      if (exp_q.size() == 0) break;
    end
    if (exp_q.size() != 0) begin
      note_failure($sformatf("%0d responses still missing after timeout", exp_q.size()));
      exp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Response monitor

  always @(posedge hb_clk) begin
    exp_resp_s e;
    for (int p = 0; p < gw_pkg::num_ports_lp; p++) begin
      if (resp_v[p] && resp_ready[p]) begin
        if (exp_q.size() == 0) begin
          note_failure($sformatf("unexpected response on port %0d", p));
        end else begin
          e = exp_q.pop_front();
          check("resp port", 64'(e.port), 64'(p));
          check("resp write", 64'(e.resp.write), 64'(resp[p].write));
          check("resp data", 64'(e.resp.data), 64'(resp[p].data));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    gw_pkg::mem_req_s r;
    logic [31:0]      d;
    int               a;
    int               p;
    bit               ok;
    bit               stalled;

    tag_en     = 1'b0;
    tag_data   = 1'b0;
    trace_done = 1'b1;
    req_v      = '0;
    req        = '0;
    resp_ready = '1;
    build_table();

    // Reset hold until a tag releases the complex
    for (int i = 0; i < timeout_lp && rst_n !== 1'b1; i++) begin
      @(posedge hb_clk);
    end
    if (rst_n !== 1'b1) note_failure("reset was never released");
    for (int i = 0; i < hold_cycles_lp; i++) begin
      @(posedge hb_clk);
      check("hold req_ready", 64'(0), 64'(req_ready));
      check("hold resp_v", 64'(0), 64'(resp_v));
    end
    send_tag(1'b0, 1'b0);
    wait_ready("first tag release");

    // Table of writes and cross-port reads
    for (int i = 0; i < num_entries_lp; i++) begin
      send(stim_tbl[i].port, stim_tbl[i].req, stim_tbl[i].exp);
    end
    drain();

    // Port 2 waits while the turn sits at port 0
    post_req(2, make_req(1'b0, 5, '0));
    for (int i = 0; i < hold_cycles_lp; i++) begin
      @(posedge hb_clk);
      check("rotation port 2 ready", 64'(0), 64'(req_ready[2]));
    end
    d = lcg_next();
    model['h100] = d;
    send(0, make_req(1'b1, 'h100, d), d);
    send(1, make_req(1'b0, 'h100, '0), d);
    wait_accept(2, 1'b0, model[5], timeout_lp, ok);
    if (!ok) note_failure("port 2 request not accepted after its turn came");
    drain();

    //////////////////////////////////////////////////
    // Back-pressure from port 1

    @(posedge hb_clk);
    resp_ready[1] <= 1'b0;
    stalled = 1'b0;
    for (int i = 0; i < 16; i++) begin
      a = (i % 2 == 0) ? 'h200 + i : 'h1ff + i;
      if (i % 2 == 0) begin
        d        = lcg_next();
        model[a] = d;
        r        = make_req(1'b1, a, d);
      end else begin
        d = model[a];
        r = make_req(1'b0, a, '0);
      end
      p = turn;
      post_req(p, r);
      wait_accept(p, r.write, d, stall_wait_lp, ok);
      if (!ok) begin
        stalled = 1'b1;
        break;
      end
    end
    if (stalled) begin
      @(posedge hb_clk);
      check("stalled req_ready", 64'(0), 64'(req_ready));
      resp_ready[1] <= 1'b1;
      wait_accept(p, r.write, d, timeout_lp, ok);
      if (!ok) note_failure("stalled request not accepted after response release");
    end else begin
      note_failure("requests never stalled under response back-pressure");
    end
    drain();

    // Re-reset by tag, then by trace done
    send_tag(1'b0, 1'b1);
    wait_quiet("tag reset");
    send_tag(1'b0, 1'b0);
    wait_ready("second tag release");
    @(posedge hb_clk);
    trace_done <= 1'b0;
    wait_quiet("trace done dropped");

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
gw_pkg.sv
gw_fifo.sv
gw_tag_client.sv
gw_link_rr_static.sv
gw_test_mem.sv
gw_core_complex.sv
tb_clk_gen.sv
tb_gw_core_complex.sv

/* Makefile */
TOP := tb_gw_core_complex

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q '\*\* PASS \*\*' sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
